//--- verilog/mips_pkg.sv
/*
  shared definitions for the 8-bit multicycle core
  widths, instruction field codes, ALU operations and datapath selects
*/

package mips_pkg;

  // --------------------
  // widths
  // --------------------
  localparam int WORD_WIDTH = 8;
  localparam int REG_BITS   = 3;

  typedef logic [WORD_WIDTH-1:0]   word_t;
  typedef logic [4*WORD_WIDTH-1:0] instr_t;
  typedef logic [REG_BITS-1:0]     reg_addr_t;
  typedef logic [5:0]              opcode_t;
  typedef logic [5:0]              funct_t;
  typedef logic [3:0]              alu_ctrl_t;

  // --------------------
  // opcodes
  // --------------------
  localparam opcode_t OP_LB    = 6'b100000;
  localparam opcode_t OP_SB    = 6'b101000;
  localparam opcode_t OP_RTYPE = 6'b000000;
  localparam opcode_t OP_BEQ   = 6'b000100;
  localparam opcode_t OP_J     = 6'b000010;

  // R-type funct field
  localparam funct_t FN_ADD   = 6'b100000;
  localparam funct_t FN_SUB   = 6'b100010;
  localparam funct_t FN_AND   = 6'b100100;
  localparam funct_t FN_OR    = 6'b100101;
  localparam funct_t FN_XOR   = 6'b110101;
  localparam funct_t FN_SLT   = 6'b101010;
  localparam funct_t FN_MLT   = 6'b101111;
  localparam funct_t FN_SHFTL = 6'b111111;
  localparam funct_t FN_SHFTR = 6'b101101;

  // --------------------
  // ALU operations
  // --------------------
  localparam alu_ctrl_t ALU_ADD = 4'd0;
  localparam alu_ctrl_t ALU_SUB = 4'd1;
  localparam alu_ctrl_t ALU_AND = 4'd2;
  localparam alu_ctrl_t ALU_OR  = 4'd3;
  localparam alu_ctrl_t ALU_XOR = 4'd4;
  localparam alu_ctrl_t ALU_SLT = 4'd5;
  localparam alu_ctrl_t ALU_MUL = 4'd6;
  localparam alu_ctrl_t ALU_SHL = 4'd7;
  localparam alu_ctrl_t ALU_SHR = 4'd8;

  // operand b select
  localparam logic [1:0] SRCB_REG   = 2'b00;
  localparam logic [1:0] SRCB_ONE   = 2'b01;
  localparam logic [1:0] SRCB_IMM   = 2'b10;
  localparam logic [1:0] SRCB_IMMX4 = 2'b11;

  // next pc select
  localparam logic [1:0] PCSRC_ALU    = 2'b00;
  localparam logic [1:0] PCSRC_ALUOUT = 2'b01;
  localparam logic [1:0] PCSRC_JUMP   = 2'b10;

endpackage

//--- verilog/mips_control.sv
/*
  control unit for the multicycle core
  state sequencing, per-state strobes and ALU operation decode
*/

`timescale 1ns/100ps

module mips_control
  (
    input  logic                 clk,
    input  logic                 reset,
    input  mips_pkg::opcode_t    op,
    input  mips_pkg::funct_t     funct,
    input  logic                 zero,
    output logic                 memread,
    output logic                 memwrite,
    output logic                 alusrca,
    output logic                 iord,
    output logic                 memtoreg,
    output logic                 regwrite,
    output logic                 regdst,
    output logic                 pcen,
    output logic [3:0]           irwrite,
    output logic [1:0]           alusrcb,
    output logic [1:0]           pcsrc,
    output mips_pkg::alu_ctrl_t  alu_ctrl
  );

  import mips_pkg::*;

  typedef enum logic [3:0] {
    FETCH1, FETCH2, FETCH3, FETCH4, DECODE, MEMADR, LBRD, LBWR,
    SBWR, RTYPEEX, RTYPEWR, BEQEX, JEX
  } state_t;

  state_t    state;
  state_t    next_state;
  logic      pcwrite;
  logic      branch;
  alu_ctrl_t rtype_ctrl;

  // --------------------
  // state register
  // --------------------
  always_ff @(posedge clk)
  begin
    if (reset)
      state <= FETCH1;
    else
      state <= next_state;
  end

  always_comb
  begin
    case (state)
      FETCH1:  next_state = FETCH2;
      FETCH2:  next_state = FETCH3;
      FETCH3:  next_state = FETCH4;
      FETCH4:  next_state = DECODE;
      DECODE:
      begin
        case (op)
          OP_LB, OP_SB: next_state = MEMADR;
          OP_RTYPE:     next_state = RTYPEEX;
          OP_BEQ:       next_state = BEQEX;
          OP_J:         next_state = JEX;
          // unknown opcode is skipped
          default:      next_state = FETCH1;
        endcase
      end
      MEMADR:  next_state = (op == OP_LB) ? LBRD : SBWR;
      LBRD:    next_state = LBWR;
      RTYPEEX: next_state = RTYPEWR;
      default: next_state = FETCH1;
    endcase
  end

  // funct decode with add for anything unknown
  always_comb
  begin
    case (funct)
      FN_SUB:   rtype_ctrl = ALU_SUB;
      FN_AND:   rtype_ctrl = ALU_AND;
      FN_OR:    rtype_ctrl = ALU_OR;
      FN_XOR:   rtype_ctrl = ALU_XOR;
      FN_SLT:   rtype_ctrl = ALU_SLT;
      FN_MLT:   rtype_ctrl = ALU_MUL;
      FN_SHFTL: rtype_ctrl = ALU_SHL;
      FN_SHFTR: rtype_ctrl = ALU_SHR;
      default:  rtype_ctrl = ALU_ADD;
    endcase
  end

  // --------------------
  // per-state outputs
  // --------------------
  always_comb
  begin
    memread  = 1'b0;
    memwrite = 1'b0;
    alusrca  = 1'b0;
    iord     = 1'b0;
    memtoreg = 1'b0;
    regwrite = 1'b0;
    regdst   = 1'b0;
    pcwrite  = 1'b0;
    branch   = 1'b0;
    irwrite  = 4'b0000;
    alusrcb  = SRCB_REG;
    pcsrc    = PCSRC_ALU;
    alu_ctrl = ALU_ADD;
    case (state)
      FETCH1, FETCH2, FETCH3, FETCH4:
      begin
        // byte lane follows the fetch step while pc counts up by one
        memread = 1'b1;
        irwrite = 4'b0001 << (state - FETCH1);
        alusrcb = SRCB_ONE;
        pcwrite = 1'b1;
      end
      // branch target into the result register
      DECODE:  alusrcb = SRCB_IMMX4;
      MEMADR:
      begin
        alusrca = 1'b1;
        alusrcb = SRCB_IMM;
      end
      LBRD:
      begin
        memread = 1'b1;
        iord    = 1'b1;
      end
      LBWR:
      begin
        regwrite = 1'b1;
        memtoreg = 1'b1;
      end
      SBWR:
      begin
        memwrite = 1'b1;
        iord     = 1'b1;
      end
      RTYPEEX:
      begin
        alusrca  = 1'b1;
        alu_ctrl = rtype_ctrl;
      end
      RTYPEWR:
      begin
        regdst   = 1'b1;
        regwrite = 1'b1;
      end
      BEQEX:
      begin
        alusrca  = 1'b1;
        alu_ctrl = ALU_SUB;
        branch   = 1'b1;
        pcsrc    = PCSRC_ALUOUT;
      end
      JEX:
      begin
        pcwrite = 1'b1;
        pcsrc   = PCSRC_JUMP;
      end
    endcase
  end

  assign pcen = pcwrite | (branch & zero);

endmodule

//--- verilog/instr_reg.sv
/*
  instruction register
  collects four fetched bytes and splits out the instruction fields
*/

`timescale 1ns/100ps

module instr_reg
  (
    input  logic                 clk,
    input  logic [3:0]           irwrite,
    input  mips_pkg::word_t      memdata,
    input  logic                 regdst,
    output mips_pkg::opcode_t    op,
    output mips_pkg::funct_t     funct,
    output mips_pkg::reg_addr_t  ra1,
    output mips_pkg::reg_addr_t  ra2,
    output mips_pkg::reg_addr_t  wa,
    output mips_pkg::word_t      imm,
    output mips_pkg::word_t      immx4
  );

  import mips_pkg::*;

  instr_t    instr;
  reg_addr_t rt;
  reg_addr_t rd;

  // one byte lane per fetch with the low byte first
  always_ff @(posedge clk)
  begin
    for (int i = 0; i < 4; i++)
    begin
      if (irwrite[i])
        instr[i*WORD_WIDTH +: WORD_WIDTH] <= memdata;
    end
  end

  assign op    = instr[31:26];
  assign funct = instr[5:0];
  assign ra1   = instr[23:21];
  assign rt    = instr[18:16];
  assign rd    = instr[13:11];
  assign ra2   = rt;
  assign wa    = regdst ? rd : rt;
  assign imm   = instr[7:0];
  assign immx4 = {instr[5:0], 2'b00};

endmodule

//--- verilog/reg_file.sv
/*
  eight-word register file
  two combinational reads and one write at the clock edge
*/

`timescale 1ns/100ps

module reg_file
  (
    input  logic                 clk,
    input  logic                 regwrite,
    input  mips_pkg::reg_addr_t  ra1,
    input  mips_pkg::reg_addr_t  ra2,
    input  mips_pkg::reg_addr_t  wa,
    input  mips_pkg::word_t      wd,
    output mips_pkg::word_t      rd1,
    output mips_pkg::word_t      rd2
  );

  import mips_pkg::*;

  word_t regs [(1 << REG_BITS)-1:0];

  always_ff @(posedge clk)
  begin
    if (regwrite)
      regs[wa] <= wd;
  end

  // r0 always reads zero even after a write
  assign rd1 = (ra1 != '0) ? regs[ra1] : '0;
  assign rd2 = (ra2 != '0) ? regs[ra2] : '0;

endmodule

//--- verilog/alu.sv
/*
  ALU for the 8-bit core
  arithmetic, logic, compare and shift results with a zero flag
*/

`timescale 1ns/100ps

module alu
  (
    input  mips_pkg::word_t      a,
    input  mips_pkg::word_t      b,
    input  mips_pkg::alu_ctrl_t  alu_ctrl,
    output mips_pkg::word_t      result,
    output logic                 zero
  );

  import mips_pkg::*;

  word_t sum;
  word_t diff;
  word_t product;
  logic [2:0] shamt;

  assign sum     = a + b;
  assign diff    = a - b;
  assign product = a * b;
  // only the low three bits of b shift
  assign shamt   = b[2:0];

  always_comb
  begin
    case (alu_ctrl)
      ALU_ADD: result = sum;
      ALU_SUB: result = diff;
      ALU_AND: result = a & b;
      ALU_OR:  result = a | b;
      ALU_XOR: result = a ^ b;
      // sign of a - b without overflow correction
      ALU_SLT: result = {{(WORD_WIDTH-1){1'b0}}, diff[WORD_WIDTH-1]};
      ALU_MUL: result = product;
      ALU_SHL: result = a << shamt;
      ALU_SHR: result = a >> shamt;
      default: result = sum;
    endcase
  end

  assign zero = (result == '0);

endmodule

//--- verilog/pc_path.sv
/*
  datapath registers and muxes
  program counter, memory address, ALU operands and write-back value
*/

`timescale 1ns/100ps

module pc_path
  (
    input  logic             clk,
    input  logic             reset,
    input  mips_pkg::word_t  memdata,
    input  mips_pkg::word_t  rd1,
    input  mips_pkg::word_t  rd2,
    input  mips_pkg::word_t  aluresult,
    input  mips_pkg::word_t  imm,
    input  mips_pkg::word_t  immx4,
    input  logic             pcen,
    input  logic             iord,
    input  logic             alusrca,
    input  logic             memtoreg,
    input  logic [1:0]       alusrcb,
    input  logic [1:0]       pcsrc,
    output mips_pkg::word_t  adr,
    output mips_pkg::word_t  writedata,
    output mips_pkg::word_t  srca,
    output mips_pkg::word_t  srcb,
    output mips_pkg::word_t  wd
  );

  import mips_pkg::*;

  word_t pc;
  word_t nextpc;
  word_t data;
  word_t a;
  word_t aluout;

  // --------------------
  // registers
  // --------------------
  always_ff @(posedge clk)
  begin
    if (reset)
      pc <= '0;
    else if (pcen)
      pc <= nextpc;
  end

  // these load every cycle
  always_ff @(posedge clk)
  begin
    data      <= memdata;
    a         <= rd1;
    writedata <= rd2;
    aluout    <= aluresult;
  end

  // --------------------
  // muxes
  // --------------------
  // pc for fetch and computed address for lb/sb
  assign adr  = iord ? aluout : pc;
  assign srca = alusrca ? a : pc;

  always_comb
  begin
    case (alusrcb)
      SRCB_REG:   srcb = writedata;
      SRCB_ONE:   srcb = word_t'(1);
      SRCB_IMM:   srcb = imm;
      default:    srcb = immx4;
    endcase
  end

  always_comb
  begin
    case (pcsrc)
      PCSRC_ALUOUT: nextpc = aluout;
      PCSRC_JUMP:   nextpc = immx4;
      default:      nextpc = aluresult;
    endcase
  end

  // loaded byte or ALU result into the register file
  assign wd = memtoreg ? data : aluout;

endmodule

//--- verilog/mips_core.sv
/*
  8-bit multicycle MIPS-like core
  control unit wired to the datapath blocks with a byte-wide memory port
*/

`timescale 1ns/100ps

module mips_core
  (
    input  logic             clk,
    input  logic             reset,
    input  mips_pkg::word_t  memdata,
    output logic             memread,
    output logic             memwrite,
    output mips_pkg::word_t  adr,
    output mips_pkg::word_t  writedata
  );

  import mips_pkg::*;

  // control to datapath
  logic       alusrca, iord, memtoreg, regwrite, regdst, pcen, zero;
  logic [3:0] irwrite;
  logic [1:0] alusrcb, pcsrc;
  alu_ctrl_t  alu_ctrl;

  // instruction fields
  opcode_t   op;
  funct_t    funct;
  reg_addr_t ra1, ra2, wa;
  word_t     imm, immx4;

  // data values
  word_t rd1, rd2, wd, srca, srcb, aluresult;

  mips_control control0 (.clk(clk), .reset(reset), .op(op), .funct(funct), .zero(zero),
    .memread(memread), .memwrite(memwrite), .alusrca(alusrca), .iord(iord),
    .memtoreg(memtoreg), .regwrite(regwrite), .regdst(regdst), .pcen(pcen),
    .irwrite(irwrite), .alusrcb(alusrcb), .pcsrc(pcsrc), .alu_ctrl(alu_ctrl));

  instr_reg ir0 (.clk(clk), .irwrite(irwrite), .memdata(memdata), .regdst(regdst),
    .op(op), .funct(funct), .ra1(ra1), .ra2(ra2), .wa(wa), .imm(imm), .immx4(immx4));

  reg_file rf0 (.clk(clk), .regwrite(regwrite), .ra1(ra1), .ra2(ra2), .wa(wa),
    .wd(wd), .rd1(rd1), .rd2(rd2));

  alu alu0 (.a(srca), .b(srcb), .alu_ctrl(alu_ctrl), .result(aluresult), .zero(zero));

  pc_path dp0 (.clk(clk), .reset(reset), .memdata(memdata), .rd1(rd1), .rd2(rd2),
    .aluresult(aluresult), .imm(imm), .immx4(immx4), .pcen(pcen), .iord(iord),
    .alusrca(alusrca), .memtoreg(memtoreg), .alusrcb(alusrcb), .pcsrc(pcsrc),
    .adr(adr), .writedata(writedata), .srca(srca), .srcb(srcb), .wd(wd));

endmodule

//--- verif/mips_tb.sv
/*
  testbench for the 8-bit multicycle core
  random program in a byte memory checked against an instruction-level model
*/

`timescale 1ns/100ps

module mips_tb;

  import mips_pkg::*;

  localparam int NUM_INSTR      = 300;
  localparam int STROBE_TIMEOUT = 16;

  logic  clk;
  logic  reset;
  word_t memdata;
  logic  memread;
  logic  memwrite;
  word_t adr;
  word_t writedata;

  word_t mem [256];

  // model state
  word_t model_mem [256];
  word_t model_regs [8];
  word_t model_pc;

  // expectations for the current instruction
  word_t   exp_fetch_pc;
  opcode_t exp_op;
  int      exp_cycles;
  word_t   exp_addr;
  word_t   exp_data;

  integer seed;
  int     cycle;
  logic   timed_out;
  int     word_errors;
  int     flag_errors;
  int     length_errors;
  int     timeouts;
  int     n_loads;
  int     n_stores;
  int     n_taken;
  int     n_not_taken;

  mips_core dut0 (.clk(clk), .reset(reset), .memdata(memdata), .memread(memread),
    .memwrite(memwrite), .adr(adr), .writedata(writedata));

  // --------------------
  // clock and memory
  // --------------------
  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  assign memdata = memread ? mem[adr] : '0;

  always @(posedge clk)
  begin
    if (memwrite)
      mem[adr] <= writedata;
  end

  // --------------------
  // compare tasks
  // --------------------
  task automatic check_word(input word_t got, input word_t exp, input string what);
    if (got !== exp)
    begin
      word_errors++;
      $display("Fail at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp)
    begin
      flag_errors++;
      $display("Fail at %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    if (got != exp)
    begin
      length_errors++;
      $display("Fail at %0t: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  // --------------------
  // reference model
  // --------------------
  function automatic word_t reg_value(input reg_addr_t idx);
    return (idx == 0) ? word_t'(0) : model_regs[idx];
  endfunction

  function automatic word_t alu_rule(input funct_t fn, input word_t a, input word_t b);
    word_t       diff;
    logic [15:0] prod;
    diff = a - b;
    prod = a * b;
    case (fn)
      FN_SUB:   return diff;
      FN_AND:   return a & b;
      FN_OR:    return a | b;
      FN_XOR:   return a ^ b;
      // sign bit of a - b
      FN_SLT:   return {7'b0, diff[7]};
      FN_MLT:   return prod[7:0];
      FN_SHFTL: return a << b[2:0];
      FN_SHFTR: return a >> b[2:0];
      default:  return a + b;
    endcase
  endfunction

  task automatic model_step();
    instr_t    ins;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    word_t     imm;
    word_t     immx4;
    word_t     va;
    word_t     vb;
    int        k;
    for (k = 0; k < 4; k++)
      ins[k*8 +: 8] = model_mem[word_t'(model_pc + k)];
    exp_fetch_pc = model_pc;
    exp_op = ins[31:26];
    rs     = ins[23:21];
    rt     = ins[18:16];
    rd     = ins[13:11];
    imm    = ins[7:0];
    immx4  = {ins[5:0], 2'b00};
    va     = reg_value(rs);
    vb     = reg_value(rt);
    model_pc = model_pc + 8'd4;
    case (exp_op)
      OP_LB:
      begin
        exp_addr = va + imm;
        exp_data = model_mem[exp_addr];
        model_regs[rt] = exp_data;
        exp_cycles = 8;
        n_loads++;
      end
      OP_SB:
      begin
        exp_addr = va + imm;
        exp_data = vb;
        model_mem[exp_addr] = vb;
        exp_cycles = 7;
        n_stores++;
      end
      OP_RTYPE:
      begin
        model_regs[rd] = alu_rule(ins[5:0], va, vb);
        exp_cycles = 7;
      end
      OP_BEQ:
      begin
        // target is relative to the pc after the fetches
        if (va == vb)
        begin
          model_pc = model_pc + immx4;
          n_taken++;
        end
        else
          n_not_taken++;
        exp_cycles = 6;
      end
      OP_J:
      begin
        model_pc = immx4;
        exp_cycles = 6;
      end
      default: exp_cycles = 5;
    endcase
  endtask

  // --------------------
  // program generation
  // --------------------
  function automatic funct_t funct_by_index(input int idx);
    case (idx)
      0:       return FN_ADD;
      1:       return FN_SUB;
      2:       return FN_AND;
      3:       return FN_OR;
      4:       return FN_XOR;
      5:       return FN_SLT;
      6:       return FN_MLT;
      7:       return FN_SHFTL;
      default: return FN_SHFTR;
    endcase
  endfunction

  task automatic make_random_instr(output instr_t ins);
    int pick;
    ins  = $random(seed);
    pick = {$random(seed)} % 5;
    case (pick)
      0: ins[31:26] = OP_LB;
      1: ins[31:26] = OP_SB;
      2:
      begin
        ins[31:26] = OP_RTYPE;
        ins[5:0]   = funct_by_index({$random(seed)} % 9);
      end
      3: ins[31:26] = OP_BEQ;
      default: ins[31:26] = OP_J;
    endcase
  endtask

  task automatic load_program();
    instr_t ins;
    int     i;
    int     k;
    for (i = 0; i < 64; i++)
    begin
      // first seven slots give r1..r7 a defined value via lb from r0
      if (i < 7)
      begin
        ins = $random(seed);
        ins[31:26] = OP_LB;
        ins[23:21] = 3'd0;
        ins[18:16] = reg_addr_t'(i + 1);
      end
      else
        make_random_instr(ins);
      for (k = 0; k < 4; k++)
      begin
        mem[i*4 + k]       = ins[k*8 +: 8];
        model_mem[i*4 + k] = ins[k*8 +: 8];
      end
    end
    for (i = 0; i < 8; i++)
      model_regs[i] = '0;
    model_pc = '0;
  endtask

  // --------------------
  // cycle walking
  // --------------------
  task automatic tick();
    @(negedge clk);
    cycle++;
  endtask

  task automatic wait_for_strobe();
    int waited;
    waited = 0;
    while (!(memread === 1'b1 || memwrite === 1'b1) && waited < STROBE_TIMEOUT)
    begin
      tick();
      waited++;
    end
    if (!(memread === 1'b1 || memwrite === 1'b1))
    begin
      timed_out = 1'b1;
      timeouts++;
      $display("timeout: no memory strobe within %0d cycles at %0t", STROBE_TIMEOUT, $time);
    end
  endtask

  task automatic run_instruction();
    int start;
    int k;
    model_step();
    start = cycle;
    for (k = 0; k < 4; k++)
    begin
      check_flag(memread, 1'b1, "memread in fetch");
      check_flag(memwrite, 1'b0, "memwrite in fetch");
      check_word(adr, exp_fetch_pc + word_t'(k), "fetch address");
      tick();
    end
    if (exp_op == OP_LB || exp_op == OP_SB)
    begin
      wait_for_strobe();
      if (timed_out)
        return;
      check_flag(memread, exp_op == OP_LB, "memread in data access");
      check_flag(memwrite, exp_op == OP_SB, "memwrite in data access");
      check_word(adr, exp_addr, "data address");
      if (exp_op == OP_SB)
        check_word(writedata, exp_data, "store data");
      tick();
    end
    // next strobe must be the following first fetch
    wait_for_strobe();
    if (timed_out)
      return;
    check_flag(memread, 1'b1, "memread at next fetch");
    check_flag(memwrite, 1'b0, "stray memwrite");
    check_count(cycle - start, exp_cycles, "instruction length");
  endtask

  // --------------------
  // main sequence
  // --------------------
  initial
  begin
    seed = 32'h61a85c2e;
    reset = 1'b1;
    cycle = 0;
    timed_out = 1'b0;
    word_errors = 0;
    flag_errors = 0;
    length_errors = 0;
    timeouts = 0;
    n_loads = 0;
    n_stores = 0;
    n_taken = 0;
    n_not_taken = 0;
    load_program();
    repeat (10) @(posedge clk);
    #1 reset = 1'b0;
    tick();
    check_flag(memwrite, 1'b0, "memwrite after reset");
    check_flag(memread, 1'b1, "memread after reset");
    check_word(adr, 8'h00, "adr after reset");
    for (int n = 0; n < NUM_INSTR; n++)
    begin
      run_instruction();
      if (timed_out)
        break;
    end
    if (!timed_out)
      check_word(adr, model_pc, "fetch address after last instruction");
    $display("ran %0d loads, %0d stores, %0d beq taken, %0d beq not taken",
      n_loads, n_stores, n_taken, n_not_taken);
    $display("errors: word %0d, flag %0d, length %0d, timeout %0d",
      word_errors, flag_errors, length_errors, timeouts);
    if (word_errors == 0 && flag_errors == 0 && length_errors == 0 && timeouts == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

//--- verilog.f
verilog/mips_pkg.sv
verilog/mips_control.sv
verilog/instr_reg.sv
verilog/reg_file.sv
verilog/alu.sv
verilog/pc_path.sv
verilog/mips_core.sv
verif/mips_tb.sv
